/* Makefile */
SIM      := verilator
VFLAGS   := --binary --timing --assert -j 0
TOP      := posMapPlbTb
FILELIST := list.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD)

/* common/leafLookupIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface leafLookupIf #(
    parameter int LeafWidth = 8,
    parameter int AddrWidth = 8,
    parameter int LeafsPerLine = 2
);
    // Request side
    logic req;                                  // One-cycle pulse
    logic [posMapPkg::CmdWidth-1:0] cmd;
    logic [AddrWidth-1:0] addr;
    logic [LeafWidth-1:0] newLeaf;
    logic initReq;                              // Map clearing only
    logic [AddrWidth-1:0] initAddr;

    // Result side
    logic resultValid;                          // One-cycle pulse
    logic hit;
    logic [LeafWidth:0] entry;
    logic busy;
    logic evict;                                // Buffer only
    logic [AddrWidth-1:0] evictAddr;
    logic [LeafsPerLine*(LeafWidth+1)-1:0] evictLine;

    modport control (
        output req, cmd, addr, newLeaf, initReq, initAddr,
        input resultValid, hit, entry, busy, evict, evictAddr, evictLine
    );

    modport posMapSide (
        input req, cmd, addr, newLeaf, initReq, initAddr,
        output resultValid, hit, entry, busy
    );

    modport plbSide (
        input req, cmd, addr, newLeaf,
        output resultValid, hit, entry, busy, evict, evictAddr, evictLine
    );

endinterface

`default_nettype wire

/* common/posMapPkg.sv */
`default_nettype none

package posMapPkg;

    // ====================
    // Command codes
    // ====================
    localparam int CmdWidth = 2;

    localparam logic [CmdWidth-1:0] CmdUpdate = 2'd0;     // Read old leaf, install random leaf
    localparam logic [CmdWidth-1:0] CmdRead = 2'd1;
    localparam logic [CmdWidth-1:0] CmdRefill = 2'd2;     // Line arrives in beats
    localparam logic [CmdWidth-1:0] CmdInitRefill = 2'd3; // Line installed as uninitialised

    // ====================
    // Default sizes
    // ====================
    localparam int DefLeafWidth = 8;
    localparam int DefAddrWidth = 8;
    localparam int DefPosMapStart = 224;  // First address held on chip
    localparam int DefLineCount = 8;
    localparam int DefLeafsPerLine = 2;

    // Entry word, LeafWidth+1 bits wide
    //   [LeafWidth]     valid, 0 means uninitialised
    //   [LeafWidth-1:0] leaf label
    // A line in the leaf buffer packs LeafsPerLine entries, slot 0 lowest

endpackage

`default_nettype wire

/* list.f */
common/posMapPkg.sv
common/leafLookupIf.sv
posMap/onChipPosMap.sv
plb/leafBuffer.sv
logic/leafPrng.sv
logic/lookupControl.sv
logic/posMapPlb.sv
verif/posMapPlbTb.sv

/* logic/leafPrng.sv */
`timescale 1ns/1ns
`default_nettype none

module leafPrng #(
    parameter int LeafWidth = 8
) (
    input wire Clock,
    input wire rstN,
    input wire leafTake,
    output logic [LeafWidth-1:0] leafValue
);
    logic [15:0] lfsr;
    logic feedback;

    // Fibonacci taps 16, 14, 13, 11 for a maximal sequence
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            lfsr <= 16'hace1;       // Any nonzero seed
        end else if (leafTake) begin
            lfsr <= {lfsr[14:0], feedback};
        end
    end

    assign leafValue = lfsr[LeafWidth-1:0];

endmodule

`default_nettype wire

/* logic/lookupControl.sv */
`timescale 1ns/1ns
`default_nettype none

module lookupControl #(
    parameter int LeafWidth = 8,
    parameter int AddrWidth = 8,
    parameter int PosMapStart = 224,
    parameter int LeafsPerLine = 2
) (
    input wire Clock,
    input wire rstN,
    input wire cmdValid,
    output logic cmdReady,
    input wire [posMapPkg::CmdWidth-1:0] cmd,
    input wire [AddrWidth-1:0] addr,
    output logic valid,
    input wire outReady,
    output logic hit,
    output logic unInit,
    output logic [LeafWidth-1:0] oldLeaf,
    output logic [LeafWidth-1:0] newLeaf,
    output logic evict,
    output logic [AddrWidth-1:0] evictAddr,
    output logic [LeafsPerLine*(LeafWidth+1)-1:0] evictLine,
    input wire [LeafWidth-1:0] leafValue,
    output logic leafTake,
    leafLookupIf.control posMapLink,
    leafLookupIf.control plbLink
);
    localparam int EntryCount = (2 ** AddrWidth) - PosMapStart;

    logic accept;
    logic inFlight;
    logic reqPulse;
    logic onChip;
    logic initActive;
    logic [AddrWidth-1:0] initCount;
    logic [posMapPkg::CmdWidth-1:0] cmdReg;
    logic [AddrWidth-1:0] addrReg;
    logic partResult;
    logic partHit;
    logic [LeafWidth:0] partEntry;
    logic updateHit;

    // One command in flight, none while the map is cleared
    assign cmdReady = !initActive && !inFlight && !posMapLink.busy && !plbLink.busy;
    assign accept = cmdValid && cmdReady;

    // ====================
    // Link requests
    // ====================
    assign posMapLink.req = reqPulse && onChip;
    assign posMapLink.cmd = cmdReg;
    assign posMapLink.addr = addrReg - AddrWidth'(PosMapStart);  // Map-relative
    assign posMapLink.newLeaf = leafValue;
    assign posMapLink.initReq = initActive;
    assign posMapLink.initAddr = initCount;

    assign plbLink.req = reqPulse && !onChip;
    assign plbLink.cmd = cmdReg;
    assign plbLink.addr = addrReg;
    assign plbLink.newLeaf = leafValue;
    assign plbLink.initReq = 1'b0;     // Buffer is never cleared
    assign plbLink.initAddr = '0;

    // Combined result
    assign partResult = posMapLink.resultValid || plbLink.resultValid;
    assign partHit = posMapLink.resultValid ? posMapLink.hit : plbLink.hit;
    assign partEntry = posMapLink.resultValid ? posMapLink.entry : plbLink.entry;
    assign updateHit = partResult && partHit && cmdReg == posMapPkg::CmdUpdate;
    assign leafTake = updateHit;       // Leaf consumed as it is written back

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            initActive <= 1'b1;
            initCount <= '0;
            inFlight <= 1'b0;
            reqPulse <= 1'b0;
            valid <= 1'b0;
        end else begin
            if (initActive) begin
                initCount <= initCount + 1'b1;
                if (initCount == AddrWidth'(EntryCount - 1)) begin
                    initActive <= 1'b0;
                end
            end
            reqPulse <= accept;
            if (accept) begin
                inFlight <= 1'b1;
            end else if (valid && outReady) begin
                inFlight <= 1'b0;
            end
            if (partResult) begin
                valid <= 1'b1;
            end else if (outReady) begin
                valid <= 1'b0;
            end
        end
    end

    // ====================
    // Command and output registers
    // ====================
    always_ff @(posedge Clock) begin
        if (accept) begin
            cmdReg <= cmd;
            addrReg <= addr;
            onChip <= addr >= AddrWidth'(PosMapStart);
        end
        if (partResult) begin
            hit <= partHit;
            unInit <= partHit && !partEntry[LeafWidth];
            oldLeaf <= partEntry[LeafWidth-1:0];
            newLeaf <= updateHit ? leafValue : partEntry[LeafWidth-1:0];
            evict <= plbLink.resultValid && plbLink.evict;
            evictAddr <= plbLink.evictAddr;
            evictLine <= plbLink.evictLine;
        end
    end

    // Each result answers the one pending command
    assert property (@(posedge Clock) disable iff (!rstN)
        partResult |-> inFlight && !valid &&
            !(posMapLink.resultValid && plbLink.resultValid))
        else $error("result without a pending command");

    // Result held until the consumer takes it
    assert property (@(posedge Clock) disable iff (!rstN)
        valid && !outReady |=> valid &&
            $stable({hit, unInit, oldLeaf, newLeaf, evict, evictAddr, evictLine}))
        else $error("output changed under back-pressure");

endmodule

`default_nettype wire

/* logic/posMapPlb.sv */
`timescale 1ns/1ns
`default_nettype none

module posMapPlb #(
    parameter int LeafWidth = posMapPkg::DefLeafWidth,
    parameter int AddrWidth = posMapPkg::DefAddrWidth,
    parameter int PosMapStart = posMapPkg::DefPosMapStart,
    parameter int LineCount = posMapPkg::DefLineCount,
    parameter int LeafsPerLine = posMapPkg::DefLeafsPerLine
) (
    input wire Clock,
    input wire rstN,
    // Command
    input wire cmdValid,
    output logic cmdReady,
    input wire [posMapPkg::CmdWidth-1:0] cmd,
    input wire [AddrWidth-1:0] addr,
    // Refill beats
    input wire refillValid,
    input wire [LeafWidth:0] refillData,
    // Result
    output logic valid,
    input wire outReady,
    output logic hit,
    output logic unInit,
    output logic [LeafWidth-1:0] oldLeaf,
    output logic [LeafWidth-1:0] newLeaf,
    output logic evict,
    output logic [AddrWidth-1:0] evictAddr,
    output logic [LeafsPerLine*(LeafWidth+1)-1:0] evictLine
);
    logic [LeafWidth-1:0] leafValue;
    logic leafTake;

    leafLookupIf #(
        .LeafWidth(LeafWidth), .AddrWidth(AddrWidth), .LeafsPerLine(LeafsPerLine)
    ) posMapLink ();

    leafLookupIf #(
        .LeafWidth(LeafWidth), .AddrWidth(AddrWidth), .LeafsPerLine(LeafsPerLine)
    ) plbLink ();

    lookupControl #(
        .LeafWidth(LeafWidth),
        .AddrWidth(AddrWidth),
        .PosMapStart(PosMapStart),
        .LeafsPerLine(LeafsPerLine)
    ) control (
        .Clock(Clock), .rstN(rstN),
        .cmdValid(cmdValid), .cmdReady(cmdReady), .cmd(cmd), .addr(addr),
        .valid(valid), .outReady(outReady), .hit(hit), .unInit(unInit),
        .oldLeaf(oldLeaf), .newLeaf(newLeaf),
        .evict(evict), .evictAddr(evictAddr), .evictLine(evictLine),
        .leafValue(leafValue), .leafTake(leafTake),
        .posMapLink(posMapLink.control), .plbLink(plbLink.control)
    );

    onChipPosMap #(
        .LeafWidth(LeafWidth), .AddrWidth(AddrWidth), .PosMapStart(PosMapStart)
    ) posMap (
        .Clock(Clock), .rstN(rstN), .link(posMapLink.posMapSide)
    );

    leafBuffer #(
        .LeafWidth(LeafWidth),
        .AddrWidth(AddrWidth),
        .LineCount(LineCount),
        .LeafsPerLine(LeafsPerLine)
    ) plb (
        .Clock(Clock), .rstN(rstN), .link(plbLink.plbSide),
        .refillValid(refillValid), .refillData(refillData)
    );

    leafPrng #(
        .LeafWidth(LeafWidth)
    ) prng (
        .Clock(Clock), .rstN(rstN), .leafTake(leafTake), .leafValue(leafValue)
    );

endmodule

`default_nettype wire

/* plb/leafBuffer.sv */
`timescale 1ns/1ns
`default_nettype none

module leafBuffer #(
    parameter int LeafWidth = 8,
    parameter int AddrWidth = 8,
    parameter int LineCount = 8,
    parameter int LeafsPerLine = 2
) (
    input wire Clock,
    input wire rstN,
    leafLookupIf.plbSide link,
    input wire refillValid,
    input wire [LeafWidth:0] refillData
);
    localparam int EntryWidth = LeafWidth + 1;
    localparam int LineWidth = LeafsPerLine * EntryWidth;
    localparam int OffsetWidth = $clog2(LeafsPerLine);
    localparam int IndexWidth = $clog2(LineCount);
    localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth;

    logic [LineWidth-1:0] lines [LineCount];
    logic [TagWidth-1:0] tags [LineCount];
    logic [LineCount-1:0] lineValid;

    logic [TagWidth-1:0] inTag;
    logic [IndexWidth-1:0] inIndex;
    logic [OffsetWidth-1:0] inOffset;
    logic [TagWidth-1:0] reqTag;
    logic [IndexWidth-1:0] reqIndex;
    logic [OffsetWidth-1:0] reqOffset;
    logic reqUpdate;
    logic refillOpen;
    logic [OffsetWidth-1:0] beatCount;
    logic lookup;
    logic initRefill;
    logic tagMatch;
    logic beatTake;
    logic lastBeat;
    logic writeBack;

    // Address split into tag, index and slot
    assign inTag = link.addr[AddrWidth-1 -: TagWidth];
    assign inIndex = link.addr[OffsetWidth +: IndexWidth];
    assign inOffset = link.addr[OffsetWidth-1:0];

    assign lookup = link.req &&
        (link.cmd == posMapPkg::CmdRead || link.cmd == posMapPkg::CmdUpdate);
    assign initRefill = link.req && link.cmd == posMapPkg::CmdInitRefill;
    assign tagMatch = lineValid[inIndex] && tags[inIndex] == inTag;
    assign beatTake = refillOpen && refillValid;
    assign lastBeat = beatTake && beatCount == OffsetWidth'(LeafsPerLine - 1);
    assign writeBack = link.resultValid && reqUpdate && link.hit;

    assign link.busy = refillOpen || (link.resultValid && reqUpdate);

    // ====================
    // Line state
    // ====================
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            lineValid <= '0;
            refillOpen <= 1'b0;
            beatCount <= '0;
            link.resultValid <= 1'b0;
        end else begin
            link.resultValid <= lookup || initRefill || lastBeat;
            if (link.req && link.cmd == posMapPkg::CmdRefill) begin
                refillOpen <= 1'b1;
                beatCount <= '0;
            end else if (beatTake) begin
                beatCount <= beatCount + 1'b1;
                if (lastBeat) begin
                    refillOpen <= 1'b0;
                end
            end
            if (initRefill) begin
                lineValid[inIndex] <= 1'b1;
            end else if (lastBeat) begin
                lineValid[reqIndex] <= 1'b1;
            end
        end
    end

    // ====================
    // Lines, tags, result
    // ====================
    always_ff @(posedge Clock) begin
        if (link.req) begin
            reqTag <= inTag;
            reqIndex <= inIndex;
            reqOffset <= inOffset;
            reqUpdate <= link.cmd == posMapPkg::CmdUpdate;
            link.hit <= lookup && tagMatch;
            link.entry <= (lookup && tagMatch) ?
                lines[inIndex][inOffset*EntryWidth +: EntryWidth] : '0;
            // Old line captured before a refill overwrites it
            link.evict <= !lookup && lineValid[inIndex];
            link.evictAddr <= {tags[inIndex], inIndex, {OffsetWidth{1'b0}}};
            link.evictLine <= lines[inIndex];
        end
        if (initRefill) begin
            lines[inIndex] <= '0;
            tags[inIndex] <= inTag;
        end
        if (beatTake) begin
            lines[reqIndex][beatCount*EntryWidth +: EntryWidth] <= refillData;
        end
        if (lastBeat) begin
            tags[reqIndex] <= reqTag;
        end
        if (writeBack) begin
            lines[reqIndex][reqOffset*EntryWidth +: EntryWidth] <= {1'b1, link.newLeaf};
        end
    end

    assert property (@(posedge Clock) disable iff (!rstN) refillValid |-> refillOpen)
        else $error("refill beat without an open refill");

endmodule

`default_nettype wire

/* posMap/onChipPosMap.sv */
`timescale 1ns/1ns
`default_nettype none

module onChipPosMap #(
    parameter int LeafWidth = 8,
    parameter int AddrWidth = 8,
    parameter int PosMapStart = 224
) (
    input wire Clock,
    input wire rstN,
    leafLookupIf.posMapSide link
);
    localparam int EntryCount = (2 ** AddrWidth) - PosMapStart;
    localparam int IndexWidth = $clog2(EntryCount);

    logic [LeafWidth:0] entries [EntryCount];

    logic [IndexWidth-1:0] reqIndex;
    logic reqUpdate;
    logic writeBack;

    // Update writes its new leaf on the edge after the result
    assign writeBack = link.resultValid && reqUpdate;

    assign link.busy = writeBack;
    assign link.hit = 1'b1;     // Every on-chip address is present

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            link.resultValid <= 1'b0;
        end else begin
            link.resultValid <= link.req;
        end
    end

    // ====================
    // Entry RAM
    // ====================
    always_ff @(posedge Clock) begin
        if (link.req) begin
            link.entry <= entries[link.addr[IndexWidth-1:0]];
            reqIndex <= link.addr[IndexWidth-1:0];
            reqUpdate <= link.cmd == posMapPkg::CmdUpdate;
        end
        if (link.initReq) begin
            entries[link.initAddr[IndexWidth-1:0]] <= '0;   // Back to uninitialised
        end else if (writeBack) begin
            entries[reqIndex] <= {1'b1, link.newLeaf};
        end
    end

    // Lookups wait until clearing has finished
    assert property (@(posedge Clock) disable iff (!rstN) !(link.req && link.initReq))
        else $error("posMap lookup during clearing");

endmodule

`default_nettype wire

/* verif/posMapPlbTb.sv */
`timescale 1ns/1ns
`default_nettype none

module posMapPlbTb;

    localparam int LeafWidth = posMapPkg::DefLeafWidth;
    localparam int AddrWidth = posMapPkg::DefAddrWidth;
    localparam int PosMapStart = posMapPkg::DefPosMapStart;
    localparam int LineCount = posMapPkg::DefLineCount;
    localparam int LeafsPerLine = posMapPkg::DefLeafsPerLine;
    localparam int EntryWidth = LeafWidth + 1;
    localparam int LineWidth = LeafsPerLine * EntryWidth;
    localparam int OffsetWidth = $clog2(LeafsPerLine);
    localparam int IndexWidth = $clog2(LineCount);
    localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth;
    localparam int EntryCount = (2 ** AddrWidth) - PosMapStart;
    localparam int MapIndexWidth = $clog2(EntryCount);
    localparam int OutWidth = 2 * LeafWidth + AddrWidth + LineWidth + 3;
    localparam int Period = 40;
    localparam int ResetCycles = 8;
    localparam int RowCount = 23;
    localparam int MaxRowCycles = 24;     // Command, beats, result, back-pressure
    localparam int RunCycles = ResetCycles + EntryCount + (EntryCount + RowCount) * MaxRowCycles;

    localparam logic [posMapPkg::CmdWidth-1:0] Update = posMapPkg::CmdUpdate;
    localparam logic [posMapPkg::CmdWidth-1:0] Read = posMapPkg::CmdRead;
    localparam logic [posMapPkg::CmdWidth-1:0] Refill = posMapPkg::CmdRefill;
    localparam logic [posMapPkg::CmdWidth-1:0] InitRefill = posMapPkg::CmdInitRefill;

    typedef struct packed {
        logic [posMapPkg::CmdWidth-1:0] cmd;
        logic [AddrWidth-1:0] addr;
        logic [LineWidth-1:0] beats;      // Slot 0 lowest
        logic expHit;
        logic expUnInit;
        logic expEvict;
        logic fromModel;                  // Old leaf from model, else expLeaf
        logic [LeafWidth-1:0] expLeaf;
    } rowT;

    logic Clock = 1'b0;
    logic rstN;
    logic cmdValid;
    logic cmdReady;
    logic [posMapPkg::CmdWidth-1:0] cmd;
    logic [AddrWidth-1:0] addr;
    logic refillValid;
    logic [EntryWidth-1:0] refillData;
    logic valid;
    logic outReady;
    logic hit;
    logic unInit;
    logic [LeafWidth-1:0] oldLeaf;
    logic [LeafWidth-1:0] newLeaf;
    logic evict;
    logic [AddrWidth-1:0] evictAddr;
    logic [LineWidth-1:0] evictLine;

    // Reference model
    logic [EntryWidth-1:0] mapModel [EntryCount];
    logic [LineWidth-1:0] lineModel [LineCount];
    logic [TagWidth-1:0] tagModel [LineCount];
    rowT rows [RowCount];
    int rowFill;
    logic [31:0] lfsrState;

    posMapPlb #(
        .LeafWidth(LeafWidth), .AddrWidth(AddrWidth), .PosMapStart(PosMapStart),
        .LineCount(LineCount), .LeafsPerLine(LeafsPerLine)
    ) i_dut (
        .Clock(Clock), .rstN(rstN),
        .cmdValid(cmdValid), .cmdReady(cmdReady), .cmd(cmd), .addr(addr),
        .refillValid(refillValid), .refillData(refillData),
        .valid(valid), .outReady(outReady), .hit(hit), .unInit(unInit),
        .oldLeaf(oldLeaf), .newLeaf(newLeaf),
        .evict(evict), .evictAddr(evictAddr), .evictLine(evictLine)
    );

    always #(Period / 2) Clock = ~Clock;

    initial begin
        #(RunCycles * Period);
        $display("Timeout: the run did not finish within %0d cycles", RunCycles);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    // ====================
    // Helpers
    // ====================
    task automatic reportMismatch(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopped at first error");
    endtask

    // Fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBits(input int count, output int value);
        int i;
        value = 0;
        for (i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);    // One step per bit
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    function automatic rowT makeRow(
        input logic [posMapPkg::CmdWidth-1:0] c, input logic [AddrWidth-1:0] a,
        input logic [LineWidth-1:0] beats, input logic h, input logic u,
        input logic e, input logic m, input logic [LeafWidth-1:0] leaf
    );
        rowT r;
        r.cmd = c;
        r.addr = a;
        r.beats = beats;
        r.expHit = h;
        r.expUnInit = u;
        r.expEvict = e;
        r.fromModel = m;
        r.expLeaf = leaf;
        return r;
    endfunction

    task automatic addRow(
        input logic [posMapPkg::CmdWidth-1:0] c, input logic [AddrWidth-1:0] a,
        input logic [LineWidth-1:0] beats, input logic h, input logic u,
        input logic e, input logic m, input logic [LeafWidth-1:0] leaf
    );
        rows[rowFill] = makeRow(c, a, beats, h, u, e, m, leaf);
        rowFill++;
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic sendCommand(input logic [posMapPkg::CmdWidth-1:0] c,
                               input logic [AddrWidth-1:0] a);
        cmdValid = 1'b1;
        cmd = c;
        addr = a;
        while (!cmdReady) begin
            @(posedge Clock);
            #1;
        end
        @(posedge Clock);         // Accepting edge
        #1;
        cmdValid = 1'b0;
    endtask

    task automatic sendBeats(input logic [LineWidth-1:0] beats);
        int i;
        @(posedge Clock);         // Refill opens one edge after acceptance
        #1;
        for (i = 0; i < LeafsPerLine; i++) begin
            refillValid = 1'b1;
            refillData = beats[i*EntryWidth +: EntryWidth];
            @(posedge Clock);
            #1;
        end
        refillValid = 1'b0;
    endtask

    task automatic applyRow(input rowT r);
        logic [IndexWidth-1:0] index;
        logic [TagWidth-1:0] tag;
        logic [OffsetWidth-1:0] offset;
        logic [MapIndexWidth-1:0] mapIndex;
        logic onChip;
        logic [EntryWidth-1:0] modelEntry;
        logic [LeafWidth-1:0] expLeaf;
        logic [AddrWidth-1:0] prevAddr;
        logic [LineWidth-1:0] prevLine;
        logic [OutWidth-1:0] held;
        int holdCycles;

        index = r.addr[OffsetWidth +: IndexWidth];
        tag = r.addr[AddrWidth-1 -: TagWidth];
        offset = r.addr[OffsetWidth-1:0];
        mapIndex = MapIndexWidth'(r.addr - AddrWidth'(PosMapStart));
        onChip = r.addr >= AddrWidth'(PosMapStart);
        modelEntry = onChip ? mapModel[mapIndex] : lineModel[index][offset*EntryWidth +: EntryWidth];
        expLeaf = r.fromModel ? modelEntry[LeafWidth-1:0] : r.expLeaf;
        prevAddr = {tagModel[index], index, {OffsetWidth{1'b0}}};
        prevLine = lineModel[index];

        sendCommand(r.cmd, r.addr);
        if (r.cmd == Refill) begin
            sendBeats(r.beats);
        end
        while (!valid) begin
            @(posedge Clock);
            #1;
        end

        assert (hit === r.expHit && unInit === r.expUnInit && evict === r.expEvict)
            else reportMismatch($sformatf("addr %0d: hit/unInit/evict %b%b%b, expected %b%b%b",
                r.addr, hit, unInit, evict, r.expHit, r.expUnInit, r.expEvict));
        if (r.expHit) begin
            assert (oldLeaf === expLeaf)
                else reportMismatch($sformatf("addr %0d: oldLeaf %h, expected %h",
                    r.addr, oldLeaf, expLeaf));
        end
        // Only an update hit installs a new leaf
        if (r.expHit && r.cmd != Update) begin
            assert (newLeaf === expLeaf)
                else reportMismatch($sformatf("addr %0d: newLeaf %h, expected %h",
                    r.addr, newLeaf, expLeaf));
        end
        if (r.expEvict) begin
            assert (evictAddr === prevAddr && evictLine === prevLine)
                else reportMismatch($sformatf("addr %0d: evicted %0d/%h, expected %0d/%h",
                    r.addr, evictAddr, evictLine, prevAddr, prevLine));
        end

        // Model follows the DUT's own new leaf
        if (r.cmd == Update && hit) begin
            if (onChip) begin
                mapModel[mapIndex] = {1'b1, newLeaf};
            end else begin
                lineModel[index][offset*EntryWidth +: EntryWidth] = {1'b1, newLeaf};
            end
        end else if (r.cmd == Refill || r.cmd == InitRefill) begin
            lineModel[index] = (r.cmd == Refill) ? r.beats : '0;
            tagModel[index] = tag;
        end

        // Back-pressure
        held = {hit, unInit, oldLeaf, newLeaf, evict, evictAddr, evictLine};
        drawBits(3, holdCycles);
        repeat (holdCycles) begin
            @(posedge Clock);
            #1;
            assert (valid && !cmdReady &&
                    {hit, unInit, oldLeaf, newLeaf, evict, evictAddr, evictLine} === held)
                else reportMismatch($sformatf("addr %0d: result not held under back-pressure",
                    r.addr));
        end
        outReady = 1'b1;
        @(posedge Clock);
        #1;
        outReady = 1'b0;
        assert (!valid)
            else reportMismatch("valid still high after the result was taken");
    endtask

    // ====================
    // Stimulus
    // ====================
    initial begin
        rstN = 1'b0;
        cmdValid = 1'b0;
        cmd = '0;
        addr = '0;
        refillValid = 1'b0;
        refillData = '0;
        outReady = 1'b0;
        lfsrState = 32'ha25e_d746;
        rowFill = 0;
        for (int i = 0; i < EntryCount; i++) begin
            mapModel[i] = '0;
        end
        for (int i = 0; i < LineCount; i++) begin
            lineModel[i] = '0;
            tagModel[i] = '0;
        end

        addRow(Update, 8'd230, '0, 1'b1, 1'b1, 1'b0, 1'b1, '0);
        addRow(Read, 8'd230, '0, 1'b1, 1'b0, 1'b0, 1'b1, '0);
        addRow(Read, 8'd231, '0, 1'b1, 1'b1, 1'b0, 1'b1, '0);
        addRow(Read, 8'd20, '0, 1'b0, 1'b0, 1'b0, 1'b1, '0);    // Empty line
        addRow(Update, 8'd20, '0, 1'b0, 1'b0, 1'b0, 1'b1, '0);
        addRow(Refill, 8'd20, {9'h0a5, 9'h13c}, 1'b0, 1'b0, 1'b0, 1'b1, '0);
        addRow(Read, 8'd20, '0, 1'b1, 1'b0, 1'b0, 1'b0, 8'h3c);
        addRow(Read, 8'd21, '0, 1'b1, 1'b1, 1'b0, 1'b0, 8'ha5);
        addRow(Read, 8'd36, '0, 1'b0, 1'b0, 1'b0, 1'b1, '0);    // Tag conflict
        addRow(Update, 8'd20, '0, 1'b1, 1'b0, 1'b0, 1'b0, 8'h3c);
        addRow(Read, 8'd20, '0, 1'b1, 1'b0, 1'b0, 1'b1, '0);
        addRow(Refill, 8'd36, {9'h122, 9'h111}, 1'b0, 1'b0, 1'b1, 1'b1, '0);
        addRow(Read, 8'd36, '0, 1'b1, 1'b0, 1'b0, 1'b0, 8'h11);
        addRow(Read, 8'd37, '0, 1'b1, 1'b0, 1'b0, 1'b0, 8'h22);
        addRow(InitRefill, 8'd86, '0, 1'b0, 1'b0, 1'b0, 1'b1, '0);
        addRow(Read, 8'd87, '0, 1'b1, 1'b1, 1'b0, 1'b1, '0);
        addRow(InitRefill, 8'd52, '0, 1'b0, 1'b0, 1'b1, 1'b1, '0);
        addRow(Read, 8'd36, '0, 1'b0, 1'b0, 1'b0, 1'b1, '0);
        addRow(Read, 8'd53, '0, 1'b1, 1'b1, 1'b0, 1'b1, '0);
        addRow(Update, 8'd53, '0, 1'b1, 1'b1, 1'b0, 1'b1, '0);
        addRow(Read, 8'd53, '0, 1'b1, 1'b0, 1'b0, 1'b1, '0);
        addRow(Update, 8'd255, '0, 1'b1, 1'b1, 1'b0, 1'b1, '0);
        addRow(Read, 8'd255, '0, 1'b1, 1'b0, 1'b0, 1'b1, '0);
        assert (rowFill == RowCount)
            else reportMismatch($sformatf("table holds %0d rows, expected %0d", rowFill, RowCount));

        repeat (ResetCycles) @(posedge Clock);
        #1;
        rstN = 1'b1;

        // Every on-chip entry starts uninitialised
        for (int a = PosMapStart; a < 2 ** AddrWidth; a++) begin
            applyRow(makeRow(Read, AddrWidth'(a), '0, 1'b1, 1'b1, 1'b0, 1'b1, '0));
        end
        for (int i = 0; i < RowCount; i++) begin
            applyRow(rows[i]);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
